// File: compile.f
+incdir+logic
logic/cp0_op_pkg.sv
logic/cp0_trap_pkg.sv
logic/cp0_regfile.sv
logic/trap_arbiter.sv
logic/cp0_ctrl.sv
logic/cp0_top.sv
tb/clk_gen.sv
tb/cp0_tb.sv

// File: logic/cp0_ctrl.sv
`timescale 1ns/1ps
`include "cp0_defs.svh"

module cp0_ctrl
    import cp0_op_pkg::*;
    import cp0_trap_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   op_req,
    input  cp0_op_req_t            op,
    output logic                   op_ack,
    input  trap_t                  trap,
    input  logic [`CP0_DATA_W-1:0] ehb,
    input  logic [`CP0_DATA_W-1:0] epc,
    output logic                   wr_en,
    output logic                   rd_en,
    output logic                   do_eret,
    output redirect_t              redirect
);

    ctrl_state_e state;
    logic        exec_go;

    // a trap in the execute cycle holds the operation back by one cycle
    assign exec_go = (state == st_exec) && !trap.take;

    assign wr_en   = exec_go && (op.op == op_mtc);
    assign rd_en   = exec_go && (op.op == op_mfc);
    assign do_eret = exec_go && (op.op == op_eret);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= st_idle;
            op_ack <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (op_req && !trap.take) begin
                        state <= st_exec;
                    end
                end
                st_exec: begin
                    if (!trap.take) begin
                        state <= st_ack;
                    end
                end
                st_ack: begin
                    if (op_req) begin
                        op_ack <= 1'b1; // hold until req drops
                    end else begin
                        op_ack <= 1'b0;
                        state  <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // one-cycle redirect, trap to handler or eret to epc
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            redirect <= '0;
        end else begin
            redirect.valid  <= trap.take || do_eret;
            redirect.flush  <= trap.take || do_eret;
            redirect.target <= trap.take ? ehb : epc;
        end
    end

    // req stays up from the execute edge until ack
    a_ack_needs_req: assert property (
        @(posedge clk) disable iff (rst) $rose(op_ack) |-> $past(op_req) && $past(op_req, 2)
    ) else $error("cp0_ctrl: op_ack rose without a held op_req");

    a_redirect_pulse: assert property (
        @(posedge clk) disable iff (rst) redirect.valid |=> !redirect.valid
    ) else $error("cp0_ctrl: redirect held longer than one cycle");

endmodule

// File: logic/cp0_defs.svh
`ifndef CP0_DEFS_SVH
`define CP0_DEFS_SVH

// datapath widths
`define CP0_DATA_W 32
`define CP0_ADDR_W 5

// register indices inside the cp0 file
`define CP0_REG_EHB    5'd3
`define CP0_REG_STATUS 5'd12
`define CP0_REG_CAUSE  5'd13
`define CP0_REG_EPC    5'd14

// handler base after reset
`define CP0_EHB_RESET 32'h0000_0024

// status enable field, all ones means traps are enabled
`define CP0_STATUS_EN_LO 8
`define CP0_STATUS_EN_HI 15

`endif

// File: logic/cp0_op_pkg.sv
`include "cp0_defs.svh"

package cp0_op_pkg;

    // operations issued by the pipeline
    typedef enum logic [2:0] {
        op_none = 3'd0,
        op_mtc  = 3'd1, // write cp0 register
        op_mfc  = 3'd2, // read cp0 register
        op_eret = 3'd3  // return from trap
    } cp0_op_e;

    // one request on the operation port, held stable while op_req is high
    typedef struct packed {
        cp0_op_e                op;
        logic [`CP0_ADDR_W-1:0] addr;
        logic [`CP0_DATA_W-1:0] wdata;
    } cp0_op_req_t;

endpackage

// File: logic/cp0_regfile.sv
`timescale 1ns/1ps
`include "cp0_defs.svh"

module cp0_regfile
    import cp0_op_pkg::*;
    import cp0_trap_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  cp0_op_req_t            op,
    input  logic                   wr_en,
    input  logic                   rd_en,
    input  trap_t                  trap,
    input  logic [`CP0_DATA_W-1:0] ret_addr,
    output logic [`CP0_DATA_W-1:0] rdata,
    output logic                   status_en,
    output logic [`CP0_DATA_W-1:0] ehb,
    output logic [`CP0_DATA_W-1:0] epc
);

    localparam int num_regs = 2 ** `CP0_ADDR_W;

    logic [`CP0_DATA_W-1:0] regs [num_regs];
    logic [`CP0_DATA_W-1:0] epc_next;
    logic [`CP0_DATA_W-1:0] cause_word;

    // exceptions resume after the faulting instruction
    assign epc_next   = trap.is_exc ? ret_addr + `CP0_DATA_W'(4) : ret_addr;
    assign cause_word = {{(`CP0_DATA_W-3){1'b0}}, trap.code};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
            regs[`CP0_REG_EHB] <= `CP0_EHB_RESET; // handler base
        end else begin
            if (wr_en) begin
                regs[op.addr] <= op.wdata; // mtc0
            end
            // trap capture comes last so it overrides an mtc0 to epc or cause
            if (trap.take) begin
                regs[`CP0_REG_EPC]   <= epc_next;
                regs[`CP0_REG_CAUSE] <= cause_word;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rdata <= regs[op.addr]; // mfc0 result, valid with op_ack
        end
    end

    assign status_en = &regs[`CP0_REG_STATUS][`CP0_STATUS_EN_HI:`CP0_STATUS_EN_LO];
    assign ehb       = regs[`CP0_REG_EHB];
    assign epc       = regs[`CP0_REG_EPC];

    // the controller decodes one operation at a time
    a_one_access: assert property (
        @(posedge clk) disable iff (rst) !(wr_en && rd_en)
    ) else $error("cp0_regfile: write and read enabled together");

endmodule

// File: logic/cp0_top.sv
`timescale 1ns/1ps
`include "cp0_defs.svh"

module cp0_top
    import cp0_op_pkg::*;
    import cp0_trap_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   op_req,
    input  cp0_op_req_t            op,
    output logic                   op_ack,
    output logic [`CP0_DATA_W-1:0] rdata,
    input  cause_e                 cause,
    input  ring_t                  irq_level,
    input  logic [`CP0_DATA_W-1:0] ret_addr,
    output redirect_t              redirect
);

    trap_t                  trap;
    logic                   status_en;
    logic                   wr_en;
    logic                   rd_en;
    logic                   do_eret;
    logic [`CP0_DATA_W-1:0] ehb;
    logic [`CP0_DATA_W-1:0] epc;

    cp0_ctrl i_ctrl (
        .clk(clk), .rst(rst),
        .op_req(op_req), .op(op), .op_ack(op_ack),
        .trap(trap), .ehb(ehb), .epc(epc),
        .wr_en(wr_en), .rd_en(rd_en), .do_eret(do_eret),
        .redirect(redirect)
    );

    trap_arbiter i_arbiter (
        .clk(clk), .rst(rst),
        .cause(cause), .irq_level(irq_level),
        .status_en(status_en), .do_eret(do_eret),
        .trap(trap)
    );

    cp0_regfile i_regfile (
        .clk(clk), .rst(rst),
        .op(op), .wr_en(wr_en), .rd_en(rd_en),
        .trap(trap), .ret_addr(ret_addr), .rdata(rdata),
        .status_en(status_en), .ehb(ehb), .epc(epc)
    );

endmodule

// File: logic/cp0_trap_pkg.sv
`include "cp0_defs.svh"

package cp0_trap_pkg;

    // internal exception codes
    typedef enum logic [2:0] {
        cause_none         = 3'd0,
        cause_undefined    = 3'd1,
        cause_overflow     = 3'd2,
        cause_out_of_range = 3'd4
    } cause_e;

    // 0 user, 1..3 interrupt levels, 4 exception
    typedef logic [2:0] ring_t;

    localparam ring_t ring_user = 3'd0;
    localparam ring_t ring_exc  = 3'd4;

    typedef struct packed {
        logic   take;     // trap accepted this cycle
        logic   is_exc;   // exception, else interrupt
        cause_e code;
        ring_t  new_ring;
    } trap_t;

    typedef struct packed {
        logic                   valid;
        logic                   flush;
        logic [`CP0_DATA_W-1:0] target;
    } redirect_t;

    typedef enum logic [1:0] {
        st_idle,
        st_exec,
        st_ack
    } ctrl_state_e;

endpackage

// File: logic/trap_arbiter.sv
`timescale 1ns/1ps

module trap_arbiter
    import cp0_trap_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  cause_e cause,
    input  ring_t  irq_level,
    input  logic   status_en,
    input  logic   do_eret,
    output trap_t  trap
);

    ring_t ring;      // current ring
    ring_t prev_ring; // single saved level
    logic  exc_hit;
    logic  irq_hit;

    assign exc_hit = status_en && (cause != cause_none);
    assign irq_hit = status_en && (irq_level > ring); // only a higher level preempts

    // exception beats an interrupt in the same cycle
    always_comb begin
        trap = '0;
        if (exc_hit) begin
            trap.take     = 1'b1;
            trap.is_exc   = 1'b1;
            trap.code     = cause;
            trap.new_ring = ring_exc;
        end else if (irq_hit) begin
            trap.take     = 1'b1;
            trap.is_exc   = 1'b0;
            trap.code     = cause_none;
            trap.new_ring = irq_level;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ring      <= ring_user;
            prev_ring <= ring_user;
        end else if (trap.take) begin
            prev_ring <= ring;
            ring      <= trap.new_ring;
        end else if (do_eret) begin
            ring <= prev_ring; // back to the interrupted level
        end
    end

    // both levels come from irq_level or the exception ring
    a_ring_range: assert property (
        @(posedge clk) disable iff (rst) (ring <= ring_exc) && (prev_ring <= ring_exc)
    ) else $error("trap_arbiter: ring out of range");

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the CP0 testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

log=sim.log
rm -rf obj_dir "$log"

if ! verilator --binary --timing --assert -f compile.f --top-module cp0_tb -o Vcp0_tb; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vcp0_tb > "$log" 2>&1
sim_status=$?
cat "$log"

if grep -q "test failed" "$log"; then
    echo "simulation reported failure"
    exit 1
fi
if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi
if ! grep -q "test passed" "$log"; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0

// File: tb/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
    output logic clk,
    output logic rst
);

    localparam int reset_cycles = 16;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk; // 40 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk); // release away from the sampling edge
        rst = 1'b0;
    end

endmodule

// File: tb/cp0_tb.sv
`timescale 1ns/1ps
`include "cp0_defs.svh"

module cp0_tb
    import cp0_op_pkg::*;
    import cp0_trap_pkg::*;
();

    localparam int wait_limit = 50;
    localparam logic [`CP0_DATA_W-1:0] status_on = 32'h0000_ff00;

    logic                   clk;
    logic                   rst;
    logic                   op_req;
    cp0_op_req_t            op;
    logic                   op_ack;
    logic [`CP0_DATA_W-1:0] rdata;
    cause_e                 cause;
    ring_t                  irq_level;
    logic [`CP0_DATA_W-1:0] ret_addr;
    redirect_t              redirect;

    logic [`CP0_DATA_W-1:0] ref_regs [32]; // reference copy of the register file
    ring_t                  ref_ring;
    ring_t                  ref_prev_ring;
    logic                   expect_redirect;
    logic [`CP0_DATA_W-1:0] exp_target;
    int                     redirect_count;
    logic [15:0]            lfsr;
    logic [`CP0_ADDR_W-1:0] addr;
    logic [`CP0_DATA_W-1:0] data;

    clk_gen i_clk_gen (.clk(clk), .rst(rst));

    cp0_top i_dut (
        .clk(clk), .rst(rst),
        .op_req(op_req), .op(op), .op_ack(op_ack), .rdata(rdata),
        .cause(cause), .irq_level(irq_level), .ret_addr(ret_addr),
        .redirect(redirect)
    );

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic value_error(input string msg);
        abort_run($sformatf("FAIL %0t: %s", $time, msg));
    endtask

    // fibonacci lfsr, x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    // every redirect must be announced by the stimulus
    always @(posedge clk) begin
        if (rst) begin
            redirect_count <= 0;
        end else if (redirect.valid) begin
            assert (expect_redirect) else value_error("redirect without a pending trap or eret");
            assert (redirect.flush) else value_error("redirect without flush");
            assert (redirect.target == exp_target)
                else value_error($sformatf("redirect target %h, expected %h",
                                           redirect.target, exp_target));
            redirect_count <= redirect_count + 1;
        end
    end

    // four-phase order on the operation port
    a_ack_after_req: assert property (@(posedge clk) disable iff (rst)
        $rose(op_ack) |-> $past(op_req)) else value_error("op_ack rose without op_req");
    a_ack_after_drop: assert property (@(posedge clk) disable iff (rst)
        $fell(op_ack) |-> !$past(op_req)) else value_error("op_ack fell while op_req was high");
    a_req_after_ack: assert property (@(posedge clk) disable iff (rst)
        $rose(op_req) |-> !op_ack) else value_error("op_req rose while op_ack was high");
    a_one_cycle_redirect: assert property (@(posedge clk) disable iff (rst)
        redirect.valid |=> !redirect.valid) else value_error("redirect longer than one cycle");

    task automatic wait_ack(input logic level, input string what);
        int n;
        n = 0;
        while (op_ack !== level) begin
            @(negedge clk);
            n++;
            if (n > wait_limit) begin
                abort_run($sformatf("timeout: %s within %0d cycles", what, wait_limit));
            end
        end
    endtask

    task automatic wait_redirect(input int start);
        int n;
        n = 0;
        while (redirect_count == start) begin
            @(negedge clk);
            n++;
            if (n > wait_limit) abort_run("timeout: the expected redirect never arrived");
        end
        expect_redirect = 1'b0;
    endtask

    task automatic run_op(input cp0_op_e kind, input logic [`CP0_ADDR_W-1:0] a,
                          input logic [`CP0_DATA_W-1:0] wdata,
                          output logic [`CP0_DATA_W-1:0] result);
        @(negedge clk);
        op.op    = kind;
        op.addr  = a;
        op.wdata = wdata;
        op_req   = 1'b1;
        wait_ack(1'b1, "op_ack did not rise");
        result = rdata;
        op_req = 1'b0;
        wait_ack(1'b0, "op_ack did not fall");
    endtask

    task automatic write_reg(input logic [`CP0_ADDR_W-1:0] a, input logic [`CP0_DATA_W-1:0] value);
        logic [`CP0_DATA_W-1:0] ignored;
        run_op(op_mtc, a, value, ignored);
        ref_regs[a] = value;
    endtask

    task automatic check_reg(input logic [`CP0_ADDR_W-1:0] a, input string name);
        logic [`CP0_DATA_W-1:0] result;
        run_op(op_mfc, a, '0, result);
        assert (result == ref_regs[a])
            else value_error($sformatf("mfc0 %s read %h, expected %h",
                                       name, result, ref_regs[a]));
    endtask

    task automatic return_from_trap();
        logic [`CP0_DATA_W-1:0] ignored;
        int                     start;
        start           = redirect_count;
        expect_redirect = 1'b1;
        exp_target      = ref_regs[`CP0_REG_EPC]; // resume where the trap hit
        run_op(op_eret, '0, '0, ignored);
        wait_redirect(start);
        ref_ring = ref_prev_ring;
    endtask

    // one cycle of cause or irq level, then check taken or masked
    task automatic raise_event(input cause_e code, input ring_t level);
        logic [`CP0_DATA_W-1:0] ret;
        logic                   enabled;
        logic                   take;
        int                     start;
        ret     = random_bits(30) << 2;
        enabled = &ref_regs[`CP0_REG_STATUS][`CP0_STATUS_EN_HI:`CP0_STATUS_EN_LO];
        take    = enabled && (code != cause_none || level > ref_ring);
        start   = redirect_count;
        @(negedge clk);
        expect_redirect = take;
        exp_target      = ref_regs[`CP0_REG_EHB];
        cause           = code;
        irq_level       = level;
        ret_addr        = ret;
        @(negedge clk);
        cause     = cause_none;
        irq_level = ring_user;
        if (take) begin
            wait_redirect(start);
            ref_prev_ring = ref_ring;
            if (code != cause_none) begin
                ref_ring                = ring_exc;
                ref_regs[`CP0_REG_EPC]   = ret + 32'd4; // past the faulting instruction
                ref_regs[`CP0_REG_CAUSE] = {{29{1'b0}}, code};
            end else begin
                ref_ring                = level;
                ref_regs[`CP0_REG_EPC]   = ret;
                ref_regs[`CP0_REG_CAUSE] = '0;
            end
        end else begin
            for (int i = 0; i < 8; i++) begin
                @(negedge clk);
                assert (redirect_count == start) else value_error("masked trap was taken");
            end
        end
    endtask

    initial begin
        op_req          = 1'b0;
        op              = '0;
        cause           = cause_none;
        irq_level       = ring_user;
        ret_addr        = '0;
        expect_redirect = 1'b0;
        exp_target      = '0;
        lfsr            = 16'd50025;
        ref_ring        = ring_user;
        ref_prev_ring   = ring_user;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        ref_regs[`CP0_REG_EHB] = `CP0_EHB_RESET;
        for (int n = 0; rst !== 1'b0; n++) begin
            if (n > wait_limit) abort_run("timeout: reset was never released");
            @(negedge clk);
        end
        @(negedge clk);
        assert (!op_ack && !redirect.valid && !redirect.flush)
            else value_error("op_ack or redirect high after reset");
        check_reg(`CP0_REG_EHB, "ehb");
        for (int i = 0; i < 4; i++) begin
            addr = 5'd16 | 5'(random_bits(3)); // general registers 16..23
            data = random_bits(32);
            write_reg(addr, data);
            check_reg(addr, "general register");
        end
        write_reg(`CP0_REG_STATUS, status_on);
        raise_event(cause_overflow, ring_user);
        check_reg(`CP0_REG_EPC, "epc");
        check_reg(`CP0_REG_CAUSE, "cause");
        return_from_trap();
        write_reg(`CP0_REG_STATUS, '0);
        raise_event(cause_undefined, ring_user);
        check_reg(`CP0_REG_CAUSE, "cause");
        write_reg(`CP0_REG_STATUS, status_on);
        write_reg(`CP0_REG_EHB, random_bits(30) << 2); // move the handler
        raise_event(cause_none, 3'd2);
        check_reg(`CP0_REG_EPC, "epc");
        raise_event(cause_none, 3'd1);
        raise_event(cause_none, 3'd2);
        raise_event(cause_none, 3'd3);
        check_reg(`CP0_REG_EPC, "epc");
        return_from_trap(); // back to ring 2
        raise_event(cause_none, 3'd2);
        raise_event(cause_none, 3'd3);
        check_reg(`CP0_REG_EPC, "epc");
        $display("test passed");
        $finish;
    end

endmodule
